/* design/cpuPkg.sv */
package cpuPkg;

    localparam int dataWidth = 32;
    localparam int addrWidth = 24;
    localparam int regIndexWidth = 4;
    localparam int immWidth = 20;

    // codes 13 to 15 are free and run as no-operation
    typedef enum logic [3:0] {
        opAdd = 4'h0,
        opSub = 4'h1,
        opAnd = 4'h2,
        opOr = 4'h3,
        opXor = 4'h4,
        opShl = 4'h5,
        opShr = 4'h6,
        opSlt = 4'h7,
        opAddi = 4'h8,
        opLoad = 4'h9,
        opStore = 4'ha,
        opBeq = 4'hb,
        opHalt = 4'hc
    } opcodeT;

    typedef enum logic [2:0] {
        aluAdd = 3'd0,
        aluSub = 3'd1,
        aluAnd = 3'd2,
        aluOr = 3'd3,
        aluXor = 3'd4,
        aluShl = 3'd5,
        aluShr = 3'd6,
        aluSlt = 3'd7
    } aluOpT;

    typedef struct packed {
        opcodeT opcode;
        logic [regIndexWidth-1:0] rz;
        logic [regIndexWidth-1:0] rx;
        logic [regIndexWidth-1:0] ry;
        logic [15:0] unused;
    } rFormT;

    typedef struct packed {
        opcodeT opcode;
        logic [regIndexWidth-1:0] rz;
        logic [regIndexWidth-1:0] rx;
        logic signed [immWidth-1:0] imm;
    } iFormT;

    typedef union packed {
        rFormT rForm;
        iFormT iForm;
    } insnWordT;

    typedef enum logic [2:0] {
        stateIdle,
        stateFetch,
        stateDecode,
        stateExecute,
        stateMemory,
        stateWriteback,
        stateHalted
    } cpuStateT;

    typedef struct packed {
        logic write;
        logic [addrWidth-1:0] addr;
        logic [dataWidth-1:0] wdata;
    } loaderReqT;

endpackage

/* design/wordMemory.sv */
`timescale 1ns/1ps

module wordMemory #(
    parameter int memDepth = 4096
) (
    input  logic clk,
    input  logic coreSel,
    input  logic [cpuPkg::addrWidth-1:0] coreAddr,
    input  logic coreWrite,
    input  logic [cpuPkg::dataWidth-1:0] coreWdata,
    input  cpuPkg::loaderReqT loader,
    output logic [cpuPkg::dataWidth-1:0] rdata
);

    localparam int indexWidth = $clog2(memDepth);

    logic [cpuPkg::dataWidth-1:0] ram [memDepth];
    logic [indexWidth-1:0] index;
    logic write;
    logic [cpuPkg::dataWidth-1:0] wdata;

    // one port, so the core and the loader take turns on it
    always_comb begin
        if (coreSel) begin
            index = coreAddr[indexWidth-1:0]; // upper address bits fold onto the array
            write = coreWrite;
            wdata = coreWdata;
        end else begin
            index = loader.addr[indexWidth-1:0];
            write = loader.write;
            wdata = loader.wdata;
        end
    end

    always_ff @(posedge clk) begin
        if (write) begin
            ram[index] <= wdata;
        end
        rdata <= ram[index]; // read-before-write on the same word
    end

endmodule

/* design/regFile.sv */
`timescale 1ns/1ps

module regFile (
    input  logic clk,
    input  logic rstN,
    input  logic writeEn,
    input  logic [cpuPkg::regIndexWidth-1:0] indexZ,
    input  logic [cpuPkg::regIndexWidth-1:0] indexX,
    input  logic [cpuPkg::regIndexWidth-1:0] indexY,
    input  logic [cpuPkg::dataWidth-1:0] writeData,
    output logic [cpuPkg::dataWidth-1:0] valueZ,
    output logic [cpuPkg::dataWidth-1:0] valueX,
    output logic [cpuPkg::dataWidth-1:0] valueY
);

    logic [cpuPkg::dataWidth-1:0] store [1 << cpuPkg::regIndexWidth];

    function automatic logic [cpuPkg::dataWidth-1:0] readPort(
        input logic [cpuPkg::regIndexWidth-1:0] index
    );
        return (index == '0) ? '0 : store[index]; // r0 is hardwired to zero
    endfunction

    always_ff @(posedge clk) begin
        if (writeEn && indexZ != '0) begin
            store[indexZ] <= writeData;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            valueZ <= '0;
            valueX <= '0;
            valueY <= '0;
        end else begin
            valueZ <= readPort(indexZ);
            valueX <= readPort(indexX);
            valueY <= readPort(indexY);
        end
    end

endmodule

/* design/alu.sv */
`timescale 1ns/1ps

module alu (
    input  cpuPkg::aluOpT op,
    input  logic [cpuPkg::dataWidth-1:0] a,
    input  logic [cpuPkg::dataWidth-1:0] b,
    output logic [cpuPkg::dataWidth-1:0] result,
    output logic equal
);

    localparam int shiftWidth = $clog2(cpuPkg::dataWidth);

    logic [shiftWidth-1:0] shamt;
    logic less;

    assign shamt = b[shiftWidth-1:0];
    assign less = $signed(a) < $signed(b);

    always_comb begin
        case (op)
            cpuPkg::aluAdd: result = a + b;
            cpuPkg::aluSub: result = a - b;
            cpuPkg::aluAnd: result = a & b;
            cpuPkg::aluOr: result = a | b;
            cpuPkg::aluXor: result = a ^ b;
            cpuPkg::aluShl: result = a << shamt;
            cpuPkg::aluShr: result = a >> shamt; // logical, zero fill
            cpuPkg::aluSlt: result = {{(cpuPkg::dataWidth - 1){1'b0}}, less};
            default: result = '0;
        endcase
    end

    // branch compare, independent of op
    assign equal = (a == b);

endmodule

/* design/programCounter.sv */
`timescale 1ns/1ps

module programCounter #(
    parameter int memDepth = 4096
) (
    input  logic clk,
    input  logic rstN,
    input  logic clear,
    input  logic increment,
    input  logic load,
    input  logic [cpuPkg::addrWidth-1:0] target,
    output logic [cpuPkg::addrWidth-1:0] pc
);

    localparam int countWidth = $clog2(memDepth);

    // narrow counter so the wrap at memDepth comes for free
    logic [countWidth-1:0] count;

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            count <= '0;
        end else if (clear) begin
            count <= '0;
        end else if (load) begin
            count <= target[countWidth-1:0];
        end else if (increment) begin
            count <= count + 1'b1;
        end
    end

    assign pc = cpuPkg::addrWidth'(count);

endmodule

/* design/controlFsm.sv */
`timescale 1ns/1ps

module controlFsm (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  logic [cpuPkg::dataWidth-1:0] memRdata,
    input  logic [cpuPkg::addrWidth-1:0] pc,
    input  logic [cpuPkg::dataWidth-1:0] valueZ,
    input  logic [cpuPkg::dataWidth-1:0] valueX,
    input  logic [cpuPkg::dataWidth-1:0] valueY,
    input  logic [cpuPkg::dataWidth-1:0] aluResult,
    input  logic aluEqual,
    output logic pcClear,
    output logic pcIncrement,
    output logic pcLoad,
    output logic [cpuPkg::addrWidth-1:0] branchTarget,
    output logic coreSel,
    output logic [cpuPkg::addrWidth-1:0] memAddr,
    output logic memWrite,
    output logic [cpuPkg::dataWidth-1:0] memWdata,
    output logic regWrite,
    output logic [cpuPkg::dataWidth-1:0] regWdata,
    output logic [cpuPkg::regIndexWidth-1:0] indexZ,
    output logic [cpuPkg::regIndexWidth-1:0] indexX,
    output logic [cpuPkg::regIndexWidth-1:0] indexY,
    output cpuPkg::aluOpT aluOp,
    output logic [cpuPkg::dataWidth-1:0] aluA,
    output logic [cpuPkg::dataWidth-1:0] aluB,
    output logic busy,
    output logic halted
);

    cpuPkg::cpuStateT state;
    cpuPkg::cpuStateT stateNext;
    cpuPkg::insnWordT insn;
    cpuPkg::insnWordT cur;
    cpuPkg::opcodeT opcode;
    logic [cpuPkg::dataWidth-1:0] result;
    logic [cpuPkg::dataWidth-1:0] immExt;
    logic branchTaken;
    logic regForm;
    logic memOp;

    // in DECODE the word is still on the memory output, later it comes from the latch
    assign cur = (state == cpuPkg::stateDecode) ? cpuPkg::insnWordT'(memRdata) : insn;
    assign opcode = cur.rForm.opcode;
    assign regForm = ~opcode[3]; // top half of the opcode space is immediate form
    assign memOp = (opcode == cpuPkg::opLoad) || (opcode == cpuPkg::opStore);
    assign immExt = {{(cpuPkg::dataWidth - cpuPkg::immWidth){cur.iForm.imm[cpuPkg::immWidth-1]}},
                     cur.iForm.imm};

    assign indexZ = cur.rForm.rz;
    assign indexX = cur.iForm.rx;
    assign indexY = regForm ? cur.rForm.ry : '0;

    assign aluOp = regForm ? cpuPkg::aluOpT'(opcode[2:0]) : cpuPkg::aluAdd;
    assign aluA = valueX;
    always_comb begin
        if (regForm) begin
            aluB = valueY;
        end else if (opcode == cpuPkg::opBeq) begin
            aluB = valueZ; // equal flag then compares rZ with rX
        end else begin
            aluB = immExt;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= cpuPkg::stateIdle;
            branchTaken <= 1'b0;
        end else begin
            state <= stateNext;
            if (state == cpuPkg::stateExecute) begin
                branchTaken <= aluEqual;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (state == cpuPkg::stateDecode) begin
            insn <= cur;
        end
        if (state == cpuPkg::stateExecute) begin
            result <= aluResult; // address for LOAD/STORE, value for the rest
        end
    end

    always_comb begin
        stateNext = state;
        case (state)
            cpuPkg::stateIdle, cpuPkg::stateHalted: begin
                if (start) begin
                    stateNext = cpuPkg::stateFetch;
                end
            end
            cpuPkg::stateFetch: stateNext = cpuPkg::stateDecode;
            cpuPkg::stateDecode: stateNext = cpuPkg::stateExecute;
            cpuPkg::stateExecute: begin
                if (opcode == cpuPkg::opHalt) begin
                    stateNext = cpuPkg::stateHalted;
                end else if (memOp) begin
                    stateNext = cpuPkg::stateMemory;
                end else begin
                    stateNext = cpuPkg::stateWriteback;
                end
            end
            cpuPkg::stateMemory: stateNext = cpuPkg::stateWriteback;
            cpuPkg::stateWriteback: stateNext = cpuPkg::stateFetch;
            default: stateNext = cpuPkg::stateIdle;
        endcase
    end

    assign halted = (state == cpuPkg::stateHalted);
    assign busy = (state != cpuPkg::stateIdle) && !halted;
    assign coreSel = busy;
    assign pcClear = start && !busy; // every run begins at address 0

    assign memAddr = (state == cpuPkg::stateMemory) ? result[cpuPkg::addrWidth-1:0] : pc;
    assign memWrite = (state == cpuPkg::stateMemory) && (opcode == cpuPkg::opStore);
    assign memWdata = valueZ;

    assign regWrite = (state == cpuPkg::stateWriteback) &&
                      (regForm || opcode == cpuPkg::opAddi || opcode == cpuPkg::opLoad);
    assign regWdata = (opcode == cpuPkg::opLoad) ? memRdata : result; // load data lands now

    assign branchTarget = pc + 1'b1 + immExt[cpuPkg::addrWidth-1:0];
    assign pcLoad = (state == cpuPkg::stateWriteback) && (opcode == cpuPkg::opBeq) && branchTaken;
    assign pcIncrement = (state == cpuPkg::stateWriteback) && !pcLoad;

endmodule

/* design/cpuTop.sv */
`timescale 1ns/1ps

module cpuTop #(
    parameter int memDepth = 4096
) (
    input  logic clk,
    input  logic rstN,
    input  logic start,
    input  cpuPkg::loaderReqT loader,
    output logic [cpuPkg::dataWidth-1:0] loadRdata,
    output logic busy,
    output logic halted
);

    logic pcClear;
    logic pcIncrement;
    logic pcLoad;
    logic [cpuPkg::addrWidth-1:0] branchTarget;
    logic [cpuPkg::addrWidth-1:0] pc;
    logic coreSel;
    logic [cpuPkg::addrWidth-1:0] memAddr;
    logic memWrite;
    logic [cpuPkg::dataWidth-1:0] memWdata;
    logic regWrite;
    logic [cpuPkg::dataWidth-1:0] regWdata;
    logic [cpuPkg::regIndexWidth-1:0] indexZ;
    logic [cpuPkg::regIndexWidth-1:0] indexX;
    logic [cpuPkg::regIndexWidth-1:0] indexY;
    logic [cpuPkg::dataWidth-1:0] valueZ;
    logic [cpuPkg::dataWidth-1:0] valueX;
    logic [cpuPkg::dataWidth-1:0] valueY;
    cpuPkg::aluOpT aluOp;
    logic [cpuPkg::dataWidth-1:0] aluA;
    logic [cpuPkg::dataWidth-1:0] aluB;
    logic [cpuPkg::dataWidth-1:0] aluResult;
    logic aluEqual;

    controlFsm controlFsm_inst (
        .clk(clk), .rstN(rstN), .start(start),
        .memRdata(loadRdata), .pc(pc),
        .valueZ(valueZ), .valueX(valueX), .valueY(valueY),
        .aluResult(aluResult), .aluEqual(aluEqual),
        .pcClear(pcClear), .pcIncrement(pcIncrement), .pcLoad(pcLoad),
        .branchTarget(branchTarget),
        .coreSel(coreSel), .memAddr(memAddr), .memWrite(memWrite), .memWdata(memWdata),
        .regWrite(regWrite), .regWdata(regWdata),
        .indexZ(indexZ), .indexX(indexX), .indexY(indexY),
        .aluOp(aluOp), .aluA(aluA), .aluB(aluB),
        .busy(busy), .halted(halted)
    );

    programCounter #(.memDepth(memDepth)) programCounter_inst (
        .clk(clk), .rstN(rstN), .clear(pcClear), .increment(pcIncrement),
        .load(pcLoad), .target(branchTarget), .pc(pc)
    );

    regFile regFile_inst (
        .clk(clk), .rstN(rstN), .writeEn(regWrite),
        .indexZ(indexZ), .indexX(indexX), .indexY(indexY), .writeData(regWdata),
        .valueZ(valueZ), .valueX(valueX), .valueY(valueY)
    );

    alu alu_inst (
        .op(aluOp), .a(aluA), .b(aluB), .result(aluResult), .equal(aluEqual)
    );

    // the registered read data doubles as the loader read-back
    wordMemory #(.memDepth(memDepth)) wordMemory_inst (
        .clk(clk), .coreSel(coreSel), .coreAddr(memAddr), .coreWrite(memWrite),
        .coreWdata(memWdata), .loader(loader), .rdata(loadRdata)
    );

endmodule

/* verif/cpuTb.sv */
`timescale 1ns/1ps

module cpuTb;

    localparam int numTests = 12;
    localparam int maxLen = 16;
    localparam int watchdogNs = numTests * (2 * maxLen * 5 + 32) * 20 + 1000; // two runs plus loading

    logic clk;
    logic rstN;
    logic start;
    cpuPkg::loaderReqT loader;
    logic [cpuPkg::dataWidth-1:0] loadRdata;
    logic busy;
    logic halted;

    logic [31:0] lfsr;
    int valueErrors;
    int otherErrors;

    string testName [numTests];
    logic [31:0] prog [numTests][maxLen];
    int progLen [numTests];
    int expCycles [numTests];
    logic [23:0] resAddr [numTests];
    logic [31:0] expWord [numTests];
    logic [23:0] preAddr [numTests];
    logic [31:0] preWord [numTests];

    cpuTop #(.memDepth(4096)) cpuTop_inst (
        .clk(clk), .rstN(rstN), .start(start), .loader(loader),
        .loadRdata(loadRdata), .busy(busy), .halted(halted)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    initial begin
        #(watchdogNs);
        $display("watchdog expired before all programs had finished");
        $display("RESULT: FAIL");
        $finish;
    end

    function automatic logic [31:0] encodeR(input logic [3:0] op, input logic [3:0] rz,
                                            input logic [3:0] rx, input logic [3:0] ry);
        return {op, rz, rx, ry, 16'h0000};
    endfunction

    function automatic logic [31:0] encodeI(input logic [3:0] op, input logic [3:0] rz,
                                            input logic [3:0] rx, input logic [19:0] imm);
        return {op, rz, rx, imm};
    endfunction

    function automatic logic [31:0] signExtend(input logic [19:0] imm);
        return {{12{imm[19]}}, imm};
    endfunction

    // op is the low three opcode bits of a register-form instruction
    function automatic logic [31:0] aluRule(input int op, input logic [31:0] a,
                                            input logic [31:0] b);
        case (op)
            0: return a + b;
            1: return a - b;
            2: return a & b;
            3: return a | b;
            4: return a ^ b;
            5: return a << b[4:0];
            6: return a >> b[4:0];
            default: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        endcase
    endfunction

    // Fibonacci LFSR with taps 32 22 2 1 that steps once for every bit drawn
    task automatic drawBits(input int count, output logic [31:0] value);
        logic feedback;
        value = '0;
        for (int i = 0; i < count; i++) begin
            feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
            value = {value[30:0], lfsr[31]};
            lfsr = {lfsr[30:0], feedback};
        end
    endtask

    task automatic addInsn(input int t, input logic [31:0] word);
        prog[t][progLen[t]] = word;
        progLen[t] = progLen[t] + 1;
        expCycles[t] = expCycles[t] + 4;
        if (word[31:28] == cpuPkg::opLoad || word[31:28] == cpuPkg::opStore) begin
            expCycles[t] = expCycles[t] + 1; // one extra MEMORY cycle
        end
    endtask

    task automatic buildTable();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] pre;
        logic taken;
        for (int t = 0; t < numTests; t++) begin
            progLen[t] = 0;
            expCycles[t] = 0;
            resAddr[t] = 24'h000200 + 24'(t);
            drawBits(32, pre);
            preWord[t] = pre;
        end
        for (int k = 0; k < 8; k++) begin
            drawBits(20, a);
            drawBits(20, b);
            testName[k] = $sformatf("alu op %0d", k);
            preAddr[k] = 24'h000300 + 24'(k); // a word the program never touches
            addInsn(k, encodeI(cpuPkg::opAddi, 4'd1, 4'd0, a[19:0]));
            addInsn(k, encodeI(cpuPkg::opAddi, 4'd2, 4'd0, b[19:0]));
            addInsn(k, encodeR(4'(k), 4'd3, 4'd1, 4'd2));
            addInsn(k, encodeI(cpuPkg::opStore, 4'd3, 4'd0, resAddr[k][19:0]));
            expWord[k] = aluRule(k, signExtend(a[19:0]), signExtend(b[19:0]));
        end
        drawBits(20, a);
        testName[8] = "r0 write";
        preAddr[8] = resAddr[8];
        addInsn(8, encodeI(cpuPkg::opAddi, 4'd0, 4'd0, a[19:0] | 20'd1));
        addInsn(8, encodeI(cpuPkg::opStore, 4'd0, 4'd0, resAddr[8][19:0]));
        expWord[8] = 32'd0;
        testName[9] = "load store";
        preAddr[9] = 24'h000400;
        addInsn(9, encodeI(cpuPkg::opAddi, 4'd1, 4'd0, 20'h003f0));
        addInsn(9, encodeI(cpuPkg::opLoad, 4'd2, 4'd1, 20'h00010)); // base plus offset gives 0x400
        addInsn(9, encodeI(cpuPkg::opAddi, 4'd2, 4'd2, 20'd1));
        addInsn(9, encodeI(cpuPkg::opStore, 4'd2, 4'd1, resAddr[9][19:0] - 20'h003f0));
        expWord[9] = preWord[9] + 32'd1;
        // taken when both operands match, and then the store is skipped
        for (int t = 10; t < 12; t++) begin
            drawBits(20, a);
            b = (t == 10) ? a : a + 32'd1;
            testName[t] = (t == 10) ? "beq taken" : "beq not taken";
            preAddr[t] = resAddr[t];
            addInsn(t, encodeI(cpuPkg::opAddi, 4'd1, 4'd0, a[19:0]));
            addInsn(t, encodeI(cpuPkg::opAddi, 4'd2, 4'd0, b[19:0]));
            addInsn(t, encodeI(cpuPkg::opBeq, 4'd1, 4'd2, 20'd1));
            addInsn(t, encodeI(cpuPkg::opStore, 4'd1, 4'd0, resAddr[t][19:0]));
            taken = (signExtend(a[19:0]) == signExtend(b[19:0]));
            if (taken) begin
                expCycles[t] = expCycles[t] - 5; // the skipped store never runs
            end
            expWord[t] = taken ? preWord[t] : signExtend(a[19:0]);
        end
        for (int t = 0; t < numTests; t++) begin
            addInsn(t, encodeI(cpuPkg::opHalt, 4'd0, 4'd0, 20'd0));
        end
    endtask

    task automatic writeWord(input logic [23:0] addr, input logic [31:0] data);
        loader.write = 1'b1;
        loader.addr = addr;
        loader.wdata = data;
        @(posedge clk);
        #1;
        loader.write = 1'b0;
    endtask

    task automatic readWord(input logic [23:0] addr, output logic [31:0] data);
        loader.addr = addr;
        @(posedge clk);
        #1;
        data = loadRdata;
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) else begin
            valueErrors++;
            $display("FAIL %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    // counts the clock edges from the one that takes start to the one that raises halted
    task automatic runProgram(input int t, output int cycles);
        start = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
        cycles = 1;
        while (!halted) begin
            assert (busy) else begin
                otherErrors++;
                $display("busy was low while %s was running", testName[t]);
            end
            @(posedge clk);
            #1;
            cycles++;
        end
        assert (!busy) else begin
            otherErrors++;
            $display("busy stayed high after %s had halted", testName[t]);
        end
    endtask

    initial begin
        logic [31:0] got;
        int cycles;
        lfsr = 32'h0f8f_a7c4;
        valueErrors = 0;
        otherErrors = 0;
        rstN = 1'b0;
        start = 1'b0;
        loader = '0;
        buildTable();
        repeat (2) @(posedge clk);
        #1;
        rstN = 1'b1;
        assert (!busy && !halted) else begin
            otherErrors++;
            $display("busy or halted was high right after reset");
        end
        for (int t = 0; t < numTests; t++) begin
            for (int i = 0; i < progLen[t]; i++) begin
                writeWord(24'(i), prog[t][i]);
            end
            writeWord(preAddr[t], preWord[t]);
            readWord(24'd0, got);
            checkValue({testName[t], " word 0"}, prog[t][0], got);
            for (int round = 0; round < 2; round++) begin // second round restarts from address 0
                runProgram(t, cycles);
                checkValue({testName[t], " cycles"}, 32'(expCycles[t]), 32'(cycles));
                readWord(resAddr[t], got);
                checkValue(testName[t], expWord[t], got);
                readWord(preAddr[t], got);
                checkValue({testName[t], " preload"},
                           (preAddr[t] == resAddr[t]) ? expWord[t] : preWord[t], got);
            end
        end
        $display("checks done: %0d value errors, %0d other errors", valueErrors, otherErrors);
        if (valueErrors == 0 && otherErrors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

endmodule

/* tb.f */
design/cpuPkg.sv
design/wordMemory.sv
design/regFile.sv
design/alu.sv
design/programCounter.sv
design/controlFsm.sv
design/cpuTop.sv
verif/cpuTb.sv

/* run.sh */
#!/bin/sh
# Compile and run the cpuTb simulation with Verilator; exit status follows the test result.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module cpuTb -f tb.f -o cpuSim
./obj_dir/cpuSim > sim.log
cat sim.log

if grep -q "^RESULT: PASS$" sim.log; then
    exit 0
else
    exit 1
fi
